// ==== include/io_defines.svh ====
`ifndef IO_DEFINES_SVH
`define IO_DEFINES_SVH

// packet field widths
`define IO_ADDR_W 16
`define IO_DATA_W 32
`define IO_ID_W 4

// outbound link credits and loader program length
`define IO_CREDITS 4
`define IO_PROG_WORDS 8
`define IO_LOAD_BASE 16'h0100

// reserved host addresses seen by the monitor
`define IO_HOST_FINISH 16'hFF00
`define IO_HOST_FAIL 16'hFF04
`define IO_HOST_PRINT 16'hFF08

`define IO_MAX_CYCLES 2000

`endif

// ==== hw/io_pkg.sv ====
package io_pkg;

  // host request class, decoded from the store address
  typedef enum logic [1:0]
  {
    OP_FINISH  = 2'd0,
    OP_FAIL    = 2'd1,
    OP_PRINT   = 2'd2,
    OP_UNKNOWN = 2'd3
  } host_op_e;

  // monitor run state
  // done is sticky until the next reset
  typedef enum logic
  {
    MON_RUN  = 1'b0,
    MON_DONE = 1'b1
  } mon_state_e;

endpackage

// ==== hw/io_program_loader.sv ====
`timescale 1ns/1ps
`include "io_defines.svh"

module io_program_loader (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               prog_we_i,
  input  logic [$clog2(`IO_PROG_WORDS)-1:0] prog_addr_i,
  input  logic [`IO_DATA_W-1:0]             prog_data_i,
  input  logic                               start_i,
  input  logic                               credit_i,
  output logic                               req_v_o,
  output logic [`IO_ADDR_W-1:0]             req_addr_o,
  output logic [`IO_DATA_W-1:0]             req_data_o,
  output logic                               load_done_o
);

  localparam int IDX_W  = $clog2(`IO_PROG_WORDS);
  localparam int CRED_W = $clog2(`IO_CREDITS + 1);

  logic [`IO_DATA_W-1:0] prog_mem [`IO_PROG_WORDS];
  logic                  active_q;
  logic [IDX_W-1:0]      idx_q;
  logic [CRED_W-1:0]     credits_q;
  logic                  send;
  logic                  last_word;

  // host-written program store
  always_ff @(posedge clk_i)
  begin
    if (prog_we_i)
      prog_mem[prog_addr_i] <= prog_data_i;
  end

  // a word goes out whenever a pass is running and a credit is left
  assign send      = active_q && (credits_q != '0);
  assign last_word = (idx_q == IDX_W'(`IO_PROG_WORDS - 1));

  assign req_v_o    = send;
  assign req_addr_o = `IO_ADDR_W'(`IO_LOAD_BASE) + `IO_ADDR_W'({idx_q, 2'b00});
  assign req_data_o = prog_mem[idx_q];

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      active_q    <= 1'b0;
      idx_q       <= '0;
      load_done_o <= 1'b0;
    end
    else if (start_i)
    begin
      active_q    <= 1'b1;
      idx_q       <= '0;
      load_done_o <= 1'b0;
    end
    else if (send)
    begin
      if (last_word)
      begin
        active_q    <= 1'b0;
        load_done_o <= 1'b1;
      end
      else
      begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  // send and return in the same cycle cancel out
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      credits_q <= CRED_W'(`IO_CREDITS);
    else
    begin
      case ({send, credit_i})
        2'b10: credits_q <= credits_q - 1'b1;
        2'b01:
        begin
          if (credits_q != CRED_W'(`IO_CREDITS))
            credits_q <= credits_q + 1'b1;
        end
        default: credits_q <= credits_q;
      endcase
    end
  end

endmodule

// ==== hw/io_packet_decode.sv ====
`timescale 1ns/1ps
`include "io_defines.svh"

module io_packet_decode (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   tile_v_i,
  input  logic [`IO_ADDR_W-1:0] tile_addr_i,
  input  logic [`IO_DATA_W-1:0] tile_data_i,
  input  logic [`IO_ID_W-1:0]   tile_id_i,
  output logic                   dec_v_o,
  output io_pkg::host_op_e       dec_op_o,
  output logic [`IO_DATA_W-1:0] dec_data_o,
  output logic [`IO_ID_W-1:0]   dec_id_o
);

  import io_pkg::*;

  host_op_e op_d;

  // exact match against the host address map
  always_comb
  begin
    case (tile_addr_i)
      `IO_HOST_FINISH: op_d = OP_FINISH;
      `IO_HOST_FAIL:   op_d = OP_FAIL;
      `IO_HOST_PRINT:  op_d = OP_PRINT;
      default:         op_d = OP_UNKNOWN;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      dec_v_o <= 1'b0;
    else
      dec_v_o <= tile_v_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (tile_v_i)
    begin
      dec_op_o   <= op_d;
      dec_data_o <= tile_data_i;
      dec_id_o   <= tile_id_i;
    end
  end

endmodule

// ==== hw/io_monitor_execute.sv ====
`timescale 1ns/1ps
`include "io_defines.svh"

module io_monitor_execute (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   dec_v_i,
  input  io_pkg::host_op_e       dec_op_i,
  input  logic [`IO_DATA_W-1:0] dec_data_i,
  input  logic [`IO_ID_W-1:0]   dec_id_i,
  output logic                   finish_o,
  output logic                   success_o,
  output logic                   timeout_o,
  output logic                   print_v_o,
  output logic [`IO_DATA_W-1:0] print_data_o,
  output logic                   exe_v_o,
  output io_pkg::host_op_e       exe_op_o,
  output logic [`IO_ID_W-1:0]   exe_id_o
);

  import io_pkg::*;

  mon_state_e  state_q;
  logic [31:0] cycle_cnt_q;
  logic        timeout_hit;
  logic        is_finish;
  logic        is_fail;
  logic        is_print;

  assign is_finish = dec_v_i && (dec_op_i == OP_FINISH);
  assign is_fail   = dec_v_i && (dec_op_i == OP_FAIL);
  assign is_print  = dec_v_i && (dec_op_i == OP_PRINT);

  // fires on the edge where the counter lands on the limit
  assign timeout_hit = ((cycle_cnt_q + 32'd1) == 32'(`IO_MAX_CYCLES));

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      cycle_cnt_q <= '0;
    else
      cycle_cnt_q <= cycle_cnt_q + 32'd1;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q   <= MON_RUN;
      finish_o  <= 1'b0;
      success_o <= 1'b0;
      timeout_o <= 1'b0;
    end
    else if (state_q == MON_RUN)
    begin
      // a request in the same cycle takes priority over the timeout
      if (is_finish)
      begin
        state_q   <= MON_DONE;
        finish_o  <= 1'b1;
        success_o <= 1'b1;
      end
      else if (is_fail)
      begin
        state_q  <= MON_DONE;
        finish_o <= 1'b1;
      end
      else if (timeout_hit)
      begin
        state_q   <= MON_DONE;
        finish_o  <= 1'b1;
        timeout_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      print_v_o <= 1'b0;
      exe_v_o   <= 1'b0;
    end
    else
    begin
      print_v_o <= is_print;
      exe_v_o   <= dec_v_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (is_print)
      print_data_o <= dec_data_i;
    if (dec_v_i)
    begin
      exe_op_o <= dec_op_i;
      exe_id_o <= dec_id_i;
    end
  end

endmodule

// ==== hw/io_response_result.sv ====
`timescale 1ns/1ps
`include "io_defines.svh"

module io_response_result (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 exe_v_i,
  input  io_pkg::host_op_e     exe_op_i,
  input  logic [`IO_ID_W-1:0] exe_id_i,
  output logic                 rsp_v_o,
  output logic [`IO_ID_W-1:0] rsp_id_o,
  output logic                 rsp_err_o
);

  import io_pkg::*;

  logic err_d;

  // only addresses outside the host map are flagged
  assign err_d = (exe_op_i == OP_UNKNOWN);

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rsp_v_o   <= 1'b0;
      rsp_err_o <= 1'b0;
    end
    else
    begin
      rsp_v_o <= exe_v_i;
      if (exe_v_i)
        rsp_err_o <= err_d;
      else
        rsp_err_o <= 1'b0;
    end
  end

  // the load id goes back to the tile unchanged
  always_ff @(posedge clk_i)
  begin
    if (exe_v_i)
      rsp_id_o <= exe_id_i;
  end

endmodule

// ==== hw/io_complex.sv ====
`timescale 1ns/1ps
`include "io_defines.svh"

module io_complex (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               prog_we_i,
  input  logic [$clog2(`IO_PROG_WORDS)-1:0] prog_addr_i,
  input  logic [`IO_DATA_W-1:0]             prog_data_i,
  input  logic                               start_i,
  output logic                               load_done_o,
  output logic                               req_v_o,
  output logic [`IO_ADDR_W-1:0]             req_addr_o,
  output logic [`IO_DATA_W-1:0]             req_data_o,
  input  logic                               credit_i,
  input  logic                               tile_v_i,
  input  logic [`IO_ADDR_W-1:0]             tile_addr_i,
  input  logic [`IO_DATA_W-1:0]             tile_data_i,
  input  logic [`IO_ID_W-1:0]               tile_id_i,
  output logic                               rsp_v_o,
  output logic [`IO_ID_W-1:0]               rsp_id_o,
  output logic                               rsp_err_o,
  output logic                               finish_o,
  output logic                               success_o,
  output logic                               timeout_o,
  output logic                               print_v_o,
  output logic [`IO_DATA_W-1:0]             print_data_o
);

  import io_pkg::*;

  logic                  dec_v;
  host_op_e              dec_op;
  logic [`IO_DATA_W-1:0] dec_data;
  logic [`IO_ID_W-1:0]   dec_id;
  logic                  exe_v;
  host_op_e              exe_op;
  logic [`IO_ID_W-1:0]   exe_id;

  // loader runs beside the monitor pipeline
  io_program_loader loader_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .prog_we_i   (prog_we_i),
    .prog_addr_i (prog_addr_i),
    .prog_data_i (prog_data_i),
    .start_i     (start_i),
    .credit_i    (credit_i),
    .req_v_o     (req_v_o),
    .req_addr_o  (req_addr_o),
    .req_data_o  (req_data_o),
    .load_done_o (load_done_o)
  );

  io_packet_decode decode_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .tile_v_i    (tile_v_i),
    .tile_addr_i (tile_addr_i),
    .tile_data_i (tile_data_i),
    .tile_id_i   (tile_id_i),
    .dec_v_o     (dec_v),
    .dec_op_o    (dec_op),
    .dec_data_o  (dec_data),
    .dec_id_o    (dec_id)
  );

  io_monitor_execute execute_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .dec_v_i      (dec_v),
    .dec_op_i     (dec_op),
    .dec_data_i   (dec_data),
    .dec_id_i     (dec_id),
    .finish_o     (finish_o),
    .success_o    (success_o),
    .timeout_o    (timeout_o),
    .print_v_o    (print_v_o),
    .print_data_o (print_data_o),
    .exe_v_o      (exe_v),
    .exe_op_o     (exe_op),
    .exe_id_o     (exe_id)
  );

  io_response_result result_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .exe_v_i   (exe_v),
    .exe_op_i  (exe_op),
    .exe_id_i  (exe_id),
    .rsp_v_o   (rsp_v_o),
    .rsp_id_o  (rsp_id_o),
    .rsp_err_o (rsp_err_o)
  );

endmodule

// ==== tests/io_complex_tb.sv ====
`timescale 1ns/1ps
`include "io_defines.svh"

module io_complex_tb;

  import io_pkg::*;

  localparam int IDX_W = $clog2(`IO_PROG_WORDS);
  localparam int TBL_N = 8;
  localparam int WATCHDOG_CYCLES = `IO_MAX_CYCLES + TBL_N * 10 + 200;

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  prog_we_i;
  logic [IDX_W-1:0]      prog_addr_i;
  logic [`IO_DATA_W-1:0] prog_data_i;
  logic                  start_i;
  logic                  load_done_o;
  logic                  req_v_o;
  logic [`IO_ADDR_W-1:0] req_addr_o;
  logic [`IO_DATA_W-1:0] req_data_o;
  logic                  credit_i;
  logic                  tile_v_i;
  logic [`IO_ADDR_W-1:0] tile_addr_i;
  logic [`IO_DATA_W-1:0] tile_data_i;
  logic [`IO_ID_W-1:0]   tile_id_i;
  logic                  rsp_v_o;
  logic [`IO_ID_W-1:0]   rsp_id_o;
  logic                  rsp_err_o;
  logic                  finish_o;
  logic                  success_o;
  logic                  timeout_o;
  logic                  print_v_o;
  logic [`IO_DATA_W-1:0] print_data_o;

  integer                seed;
  logic [`IO_DATA_W-1:0] prog_words [`IO_PROG_WORDS];
  int                    sent_cnt;
  int                    link_cycle;
  int                    last_send_cycle;

  // inbound request table with the status packed as {finish, success, timeout}
  string                 tbl_name [TBL_N];
  logic [`IO_ADDR_W-1:0] tbl_addr [TBL_N];
  logic [`IO_DATA_W-1:0] tbl_data [TBL_N];
  logic [`IO_ID_W-1:0]   tbl_id [TBL_N];
  host_op_e              tbl_op [TBL_N];
  logic [2:0]            tbl_status [TBL_N];

  io_complex dut_i (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired before the tests completed");
    $display("TESTS FAILED");
    $fatal(1, "run stopped by watchdog");
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, exp, act);
    $display("TESTS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_problem(input string what);
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else report_mismatch(name, exp, act);
  endtask

  task automatic apply_reset();
    rst_n_i = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_n_i = 1'b1;
  endtask

  // one falling edge on the outbound link with a check of any request seen there
  task automatic step_link(input string name);
    @(negedge clk_i);
    link_cycle++;
    if (req_v_o)
    begin
      if (sent_cnt >= `IO_PROG_WORDS)
        report_problem({name, ": request strobe after the last program word"});
      check_value({name, " addr"}, 32'(`IO_LOAD_BASE + 4 * sent_cnt), 32'(req_addr_o));
      check_value({name, " data"}, prog_words[sent_cnt], req_data_o);
      sent_cnt++;
      last_send_cycle = link_cycle;
    end
  endtask

  task automatic start_pass(input string name);
    sent_cnt = 0;
    start_i  = 1'b1;
    step_link(name);
    start_i  = 1'b0;
  endtask

  task automatic set_row(input int i, input string name, input logic [15:0] addr,
                         input logic [31:0] data, input logic [3:0] id,
                         input host_op_e op, input logic [2:0] status);
    tbl_name[i]   = name;
    tbl_addr[i]   = addr;
    tbl_data[i]   = data;
    tbl_id[i]     = id;
    tbl_op[i]     = op;
    tbl_status[i] = status;
  endtask

  initial
  begin
    int cycles;

    rst_n_i     = 1'b0;
    prog_we_i   = 1'b0;
    prog_addr_i = '0;
    prog_data_i = '0;
    start_i     = 1'b0;
    credit_i    = 1'b0;
    tile_v_i    = 1'b0;
    tile_addr_i = '0;
    tile_data_i = '0;
    tile_id_i   = '0;
    seed        = 32'h25b0;
    sent_cnt    = 0;
    link_cycle  = 0;
    last_send_cycle = 0;

    set_row(0, "print_a", `IO_HOST_PRINT, 32'h0000_0041, 4'd1, OP_PRINT, 3'b000);
    set_row(1, "stray_low", 16'h0100, 32'h0000_0011, 4'd2, OP_UNKNOWN, 3'b000);
    set_row(2, "print_b", `IO_HOST_PRINT, 32'hCAFE_0042, 4'd3, OP_PRINT, 3'b000);
    set_row(3, "near_miss", 16'hFF0C, 32'h0000_0000, 4'd4, OP_UNKNOWN, 3'b000);
    set_row(4, "finish", `IO_HOST_FINISH, 32'h0000_0000, 4'd5, OP_FINISH, 3'b110);
    set_row(5, "late_fail", `IO_HOST_FAIL, 32'h0000_0001, 4'd6, OP_FAIL, 3'b110);
    set_row(6, "print_after", `IO_HOST_PRINT, 32'h0BAD_F00D, 4'd7, OP_PRINT, 3'b110);
    set_row(7, "stray_high", 16'hFFFF, 32'h0000_0000, 4'd15, OP_UNKNOWN, 3'b110);

    apply_reset();
    check_value("reset req_v", 0, req_v_o);
    check_value("reset load_done", 0, load_done_o);
    check_value("reset rsp_v", 0, rsp_v_o);
    check_value("reset rsp_err", 0, rsp_err_o);
    check_value("reset print_v", 0, print_v_o);
    check_value("reset status", 0, {finish_o, success_o, timeout_o});

    for (int i = 0; i < `IO_PROG_WORDS; i++)
    begin
      prog_words[i] = $random(seed);
      @(negedge clk_i);
      prog_we_i   = 1'b1;
      prog_addr_i = IDX_W'(i);
      prog_data_i = prog_words[i];
    end
    @(negedge clk_i);
    prog_we_i = 1'b0;

    // credits handed back every cycle so the pass never stalls
    credit_i = 1'b1;
    start_pass("free_load");
    cycles = 0;
    while (!load_done_o && cycles < 40)
    begin
      step_link("free_load");
      cycles++;
    end
    if (!load_done_o)
      report_problem("load_done_o never rose after the free-running pass");
    check_value("free_load count", `IO_PROG_WORDS, sent_cnt);
    check_value("free_load done delay", last_send_cycle + 1, link_cycle);
    credit_i = 1'b0;

    start_pass("stall_load");
    repeat (12) step_link("stall_load");
    check_value("stall_load count", `IO_CREDITS, sent_cnt);
    check_value("stall_load done low", 0, load_done_o);
    for (int k = 1; k <= `IO_PROG_WORDS - `IO_CREDITS; k++)
    begin
      credit_i = 1'b1;
      step_link("stall_release");
      credit_i = 1'b0;
      repeat (6) step_link("stall_release");
      check_value("stall_release count", `IO_CREDITS + k, sent_cnt);
    end
    check_value("stall_load done", 1, load_done_o);

    // back-to-back requests with print and status two edges later and the ack three
    for (int k = 0; k < TBL_N + 3; k++)
    begin
      @(negedge clk_i);
      if (k >= 2 && k < TBL_N + 2)
      begin
        check_value({tbl_name[k-2], " print_v"}, tbl_op[k-2] == OP_PRINT, print_v_o);
        if (tbl_op[k-2] == OP_PRINT)
          check_value({tbl_name[k-2], " print_data"}, tbl_data[k-2], print_data_o);
        check_value({tbl_name[k-2], " status"}, tbl_status[k-2],
                    {finish_o, success_o, timeout_o});
      end
      if (k >= 3)
      begin
        check_value({tbl_name[k-3], " rsp_v"}, 1, rsp_v_o);
        check_value({tbl_name[k-3], " rsp_id"}, tbl_id[k-3], rsp_id_o);
        check_value({tbl_name[k-3], " rsp_err"}, tbl_op[k-3] == OP_UNKNOWN, rsp_err_o);
      end
      if (k < TBL_N)
      begin
        tile_v_i    = 1'b1;
        tile_addr_i = tbl_addr[k];
        tile_data_i = tbl_data[k];
        tile_id_i   = tbl_id[k];
      end
      else
        tile_v_i = 1'b0;
    end

    // second run with no finish request so the cycle limit ends it
    apply_reset();
    cycles = 0;
    while (!finish_o && cycles < `IO_MAX_CYCLES + 50)
    begin
      @(negedge clk_i);
      cycles++;
    end
    check_value("timeout cycles", `IO_MAX_CYCLES, cycles);
    check_value("timeout status", 3'b101, {finish_o, success_o, timeout_o});

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+include
hw/io_pkg.sv
hw/io_program_loader.sv
hw/io_packet_decode.sv
hw/io_monitor_execute.sv
hw/io_response_result.sv
hw/io_complex.sv
tests/io_complex_tb.sv

// ==== Bender.yml ====
package:
  name: io_complex

sources:
  - include_dirs:
      - include
    files:
      - hw/io_pkg.sv
      - hw/io_program_loader.sv
      - hw/io_packet_decode.sv
      - hw/io_monitor_execute.sv
      - hw/io_response_result.sv
      - hw/io_complex.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/io_complex_tb.sv
